/* source/store_params.svh */
`ifndef STORE_PARAMS_SVH
`define STORE_PARAMS_SVH

// store queue geometry
`define STQ_DEPTH 16
`define STQ_PTR_W 4

// store payload
// addr bits 1:0 byte in bank, 6:2 bank, upper bits line
`define ST_ADDR_W 16
`define ST_DATA_W 32

// banked data cache
`define BANK_W 5
`define BEN_W 4

// two-bank write window
`define LANE_W 64

`endif

/* source/store_pkg.sv */
`default_nettype none

package store_pkg;

`include "store_params.svh"

  // store size in bytes; value 3 unused
  typedef enum logic [1:0] {
    SIZE_1 = 2'd0,
    SIZE_2 = 2'd1,
    SIZE_4 = 2'd2
  } st_size_t;

  // one queued store, 50 bits
  typedef struct packed {
    logic [`ST_ADDR_W-1:0] addr;
    st_size_t              size;
    logic [`ST_DATA_W-1:0] data;
  } st_entry_t;

  // drain side follows the cache hold one cycle late
  typedef enum logic {
    RUN  = 1'b0,
    HOLD = 1'b1
  } drain_state_t;

endpackage

`default_nettype wire

/* source/store_queue_count.sv */
`timescale 1ns/100ps
`default_nettype none

`include "store_params.svh"

module store_queue_count (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 st_in_valid,
  input  wire logic                 pop0,
  input  wire logic                 pop1,
  output logic                      accept,
  output logic [`STQ_PTR_W-1:0]     head_ptr,
  output logic [`STQ_PTR_W-1:0]     tail_ptr,
  output logic [`STQ_PTR_W:0]       count,
  output logic                      st_full
);

  localparam int PTR_W = `STQ_PTR_W;
  localparam int CNT_W = `STQ_PTR_W + 1;

  logic [1:0] pop_n;

  assign st_full = (count == CNT_W'(`STQ_DEPTH));
  assign accept  = st_in_valid & ~st_full;
  assign pop_n   = {1'b0, pop0} + {1'b0, pop1};

  // pointers wrap at the power-of-two depth
  always_ff @(posedge clk) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      if (accept) begin
        tail_ptr <= tail_ptr + PTR_W'(1);
      end
      head_ptr <= head_ptr + PTR_W'(pop_n);
      count    <= count + CNT_W'(accept) - CNT_W'(pop_n);
    end
  end

  // source must respect st_full
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (reset) !(st_in_valid && st_full)
  );

  a_count_bound: assert property (
    @(posedge clk) disable iff (reset) count <= CNT_W'(`STQ_DEPTH)
  );

endmodule

`default_nettype wire

/* source/store_entry_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "store_params.svh"

module store_entry_buffer (
  input  wire logic                  clk,
  input  wire logic                  accept,
  input  wire logic [`STQ_PTR_W-1:0] tail_ptr,
  input  wire logic [`STQ_PTR_W-1:0] head_ptr,
  input  wire logic [`ST_ADDR_W-1:0] st_in_addr,
  input  store_pkg::st_size_t        st_in_size,
  input  wire logic [`ST_DATA_W-1:0] st_in_data,
  output store_pkg::st_entry_t       head_entry,
  output store_pkg::st_entry_t       next_entry
);

  import store_pkg::*;

  localparam int PTR_W = `STQ_PTR_W;

  st_entry_t              mem [`STQ_DEPTH];
  st_entry_t              wr_entry;
  logic [`STQ_PTR_W-1:0]  next_ptr;

  assign wr_entry.addr = st_in_addr;
  assign wr_entry.size = st_in_size;
  assign wr_entry.data = st_in_data;

  always_ff @(posedge clk) begin
    if (accept) begin
      mem[tail_ptr] <= wr_entry;
    end
  end

  // second oldest wraps with the pointer
  assign next_ptr = head_ptr + PTR_W'(1);

  // both drain candidates read combinationally
  assign head_entry = mem[head_ptr];
  assign next_entry = mem[next_ptr];

endmodule

`default_nettype wire

/* source/store_bank_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "store_params.svh"

module store_bank_decode (
  input  store_pkg::st_entry_t   entry,
  output logic [`BANK_W-1:0]     bank_bgn,
  output logic [`BANK_W-1:0]     bank_end,
  output logic [`BEN_W-1:0]      bgn_ben,
  output logic [`BEN_W-1:0]      end_ben,
  output logic [`LANE_W-1:0]     lane_data
);

  import store_pkg::*;

  localparam int OFF_W = $clog2(`BEN_W);
  localparam int WIN_B = 2 * `BEN_W;

  logic [OFF_W-1:0] low;
  logic [WIN_B-1:0] size_mask;
  logic [WIN_B-1:0] byte_mask;

  assign low      = entry.addr[OFF_W-1:0];
  assign bank_bgn = entry.addr[OFF_W+`BANK_W-1:OFF_W];

  always_comb begin
    case (entry.size)
      SIZE_1:  size_mask = WIN_B'(8'b0000_0001);
      SIZE_2:  size_mask = WIN_B'(8'b0000_0011);
      SIZE_4:  size_mask = WIN_B'(8'b0000_1111);
      default: size_mask = WIN_B'(8'b0000_1111);
    endcase
  end

  // bytes placed in the eight-byte window at the begin bank
  assign byte_mask = size_mask << low;
  assign bgn_ben   = byte_mask[`BEN_W-1:0];
  assign end_ben   = byte_mask[WIN_B-1:`BEN_W];

  // overflow into the next bank, 31 wraps to 0
  assign bank_end = (|end_ben) ? bank_bgn + `BANK_W'(1) : bank_bgn;

  assign lane_data = {{(`LANE_W-`ST_DATA_W){1'b0}}, entry.data} << {low, 3'b000};

endmodule

`default_nettype wire

/* source/store_drain_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

`include "store_params.svh"

module store_drain_fsm (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                cache_hold,
  input  wire logic [`STQ_PTR_W:0] count,
  input  wire logic [`BANK_W-1:0]  head_bgn,
  input  wire logic [`BANK_W-1:0]  head_end,
  input  wire logic [`BANK_W-1:0]  next_bgn,
  input  wire logic [`BANK_W-1:0]  next_end,
  output logic                     pop0,
  output logic                     pop1
);

  import store_pkg::*;

  drain_state_t state;
  drain_state_t state_nxt;

  logic has_one;
  logic has_two;
  logic bank_clash;

  // registered copy of the cache hold
  assign state_nxt = cache_hold ? HOLD : RUN;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= RUN;
    end else begin
      state <= state_nxt;
    end
  end

  assign has_one = |count;
  // count of two or more
  assign has_two = |count[`STQ_PTR_W:1];

  // any of the four bank pairs collide
  assign bank_clash = (next_bgn == head_bgn) || (next_bgn == head_end) ||
                      (next_end == head_bgn) || (next_end == head_end);

  always_comb begin
    pop0 = 1'b0;
    pop1 = 1'b0;
    if (state == RUN) begin
      pop0 = has_one;
      pop1 = has_two && !bank_clash;
    end
  end

  // second port only rides along with the first
  a_pop1_needs_pop0: assert property (
    @(posedge clk) disable iff (reset) pop1 |-> pop0
  );

  // clash test assumes each range is one bank or two neighbours
  a_bank_span: assert property (
    @(posedge clk) disable iff (reset)
      has_two |-> ((head_end - head_bgn) <= `BANK_W'(1)) &&
                  ((next_end - next_bgn) <= `BANK_W'(1))
  );

endmodule

`default_nettype wire

/* source/store_write_path.sv */
`timescale 1ns/100ps
`default_nettype none

`include "store_params.svh"

module store_write_path (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  st_in_valid,
  input  wire logic [`ST_ADDR_W-1:0] st_in_addr,
  input  store_pkg::st_size_t        st_in_size,
  input  wire logic [`ST_DATA_W-1:0] st_in_data,
  input  wire logic                  cache_hold,
  output logic                       st_full,
  output logic                       wr0_en,
  output logic [`ST_ADDR_W-1:0]      wr0_addr,
  output logic [`BANK_W-1:0]         wr0_bank_end,
  output logic [`BEN_W-1:0]          wr0_bgn_ben,
  output logic [`BEN_W-1:0]          wr0_end_ben,
  output logic [`LANE_W-1:0]         wr0_data,
  output logic                       wr1_en,
  output logic [`ST_ADDR_W-1:0]      wr1_addr,
  output logic [`BANK_W-1:0]         wr1_bank_end,
  output logic [`BEN_W-1:0]          wr1_bgn_ben,
  output logic [`BEN_W-1:0]          wr1_end_ben,
  output logic [`LANE_W-1:0]         wr1_data
);

  import store_pkg::*;

  logic                  accept;
  logic                  pop0;
  logic                  pop1;
  logic [`STQ_PTR_W-1:0] head_ptr;
  logic [`STQ_PTR_W-1:0] tail_ptr;
  logic [`STQ_PTR_W:0]   count;

  st_entry_t             head_entry;
  st_entry_t             next_entry;

  logic [`BANK_W-1:0]    head_bgn, head_end;
  logic [`BANK_W-1:0]    next_bgn, next_end;
  logic [`BEN_W-1:0]     head_bgn_ben, head_end_ben;
  logic [`BEN_W-1:0]     next_bgn_ben, next_end_ben;
  logic [`LANE_W-1:0]    head_lane, next_lane;

  store_queue_count u_count (
    .clk(clk), .reset(reset), .st_in_valid(st_in_valid),
    .pop0(pop0), .pop1(pop1), .accept(accept),
    .head_ptr(head_ptr), .tail_ptr(tail_ptr), .count(count), .st_full(st_full)
  );

  store_entry_buffer u_buffer (
    .clk(clk), .accept(accept), .tail_ptr(tail_ptr), .head_ptr(head_ptr),
    .st_in_addr(st_in_addr), .st_in_size(st_in_size), .st_in_data(st_in_data),
    .head_entry(head_entry), .next_entry(next_entry)
  );

  store_bank_decode u_dec_head (
    .entry(head_entry), .bank_bgn(head_bgn), .bank_end(head_end),
    .bgn_ben(head_bgn_ben), .end_ben(head_end_ben), .lane_data(head_lane)
  );

  store_bank_decode u_dec_next (
    .entry(next_entry), .bank_bgn(next_bgn), .bank_end(next_end),
    .bgn_ben(next_bgn_ben), .end_ben(next_end_ben), .lane_data(next_lane)
  );

  store_drain_fsm u_drain (
    .clk(clk), .reset(reset), .cache_hold(cache_hold), .count(count),
    .head_bgn(head_bgn), .head_end(head_end),
    .next_bgn(next_bgn), .next_end(next_end),
    .pop0(pop0), .pop1(pop1)
  );

  // write strobes, one cycle after the pop
  always_ff @(posedge clk) begin
    if (reset) begin
      wr0_en <= 1'b0;
      wr1_en <= 1'b0;
    end else begin
      wr0_en <= pop0;
      wr1_en <= pop1;
    end
  end

  // payload captured only on issue
  always_ff @(posedge clk) begin
    if (pop0) begin
      wr0_addr     <= head_entry.addr;
      wr0_bank_end <= head_end;
      wr0_bgn_ben  <= head_bgn_ben;
      wr0_end_ben  <= head_end_ben;
      wr0_data     <= head_lane;
    end
    if (pop1) begin
      wr1_addr     <= next_entry.addr;
      wr1_bank_end <= next_end;
      wr1_bgn_ben  <= next_bgn_ben;
      wr1_end_ben  <= next_end_ben;
      wr1_data     <= next_lane;
    end
  end

endmodule

`default_nettype wire

/* bench/store_ref_model.svh */
`ifndef STORE_REF_MODEL_SVH
`define STORE_REF_MODEL_SVH

// accepted stores that have not yet shown up on a write port
st_entry_t exp_q[$];

// cache_hold seen in the last two cycles
logic hold_d1 = 1'b0;
logic hold_d2 = 1'b0;

int unsigned accepted_count = 0;
int unsigned cross_seen     = 0;
int unsigned wrap_seen      = 0;

function automatic int size_bytes(input st_size_t size);
  case (size)
    SIZE_1:  return 1;
    SIZE_2:  return 2;
    default: return 4;
  endcase
endfunction

// expected cache write for one store
function automatic void decode_store(
  input  st_entry_t              e,
  output logic [`BANK_W-1:0]     bgn,
  output logic [`BANK_W-1:0]     bend,
  output logic [`BEN_W-1:0]      bben,
  output logic [`BEN_W-1:0]      eben,
  output logic [`LANE_W-1:0]     lane
);
  int        low;
  int        n;
  int        i;
  logic [7:0] mask;

  low  = int'(e.addr[1:0]);
  n    = size_bytes(e.size);
  bgn  = e.addr[`BANK_W+1:2];
  mask = 8'd0;
  // one bit per byte in the two-bank window
  for (i = 0; i < n; i++) begin
    mask = mask | (8'd1 << (low + i));
  end
  bben = mask[3:0];
  eben = mask[7:4];
  if (eben != 4'd0) begin
    bend = `BANK_W'((int'(bgn) + 1) % 32);
  end else begin
    bend = bgn;
  end
  lane = `LANE_W'(e.data) << (8 * low);
endfunction

`endif

/* bench/store_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "store_params.svh"

module store_tb;

  import store_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int STIM_CYCLES  = 4000;
  localparam int DRAIN_CYCLES = 200;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + STIM_CYCLES + 2 * DRAIN_CYCLES) * CLK_PERIOD;
  localparam int SEED         = 98000;

  logic                  clk;
  logic                  reset;
  logic                  st_in_valid;
  logic [`ST_ADDR_W-1:0] st_in_addr;
  st_size_t              st_in_size;
  logic [`ST_DATA_W-1:0] st_in_data;
  logic                  cache_hold;
  logic                  st_full;
  logic                  wr0_en, wr1_en;
  logic [`ST_ADDR_W-1:0] wr0_addr, wr1_addr;
  logic [`BANK_W-1:0]    wr0_bank_end, wr1_bank_end;
  logic [`BEN_W-1:0]     wr0_bgn_ben, wr1_bgn_ben;
  logic [`BEN_W-1:0]     wr0_end_ben, wr1_end_ben;
  logic [`LANE_W-1:0]    wr0_data, wr1_data;

  int          hold_left;
  int          cyc;
  int          drain_wait;
  int unsigned error_count    = 0;
  int unsigned writes_checked = 0;
  int unsigned sample_cyc     = 0;
  int unsigned acc_cyc_q[$];
  logic        full_seen      = 1'b0;

  `include "store_ref_model.svh"

  store_write_path dut0 (
    .clk(clk), .reset(reset), .st_in_valid(st_in_valid), .st_in_addr(st_in_addr),
    .st_in_size(st_in_size), .st_in_data(st_in_data), .cache_hold(cache_hold),
    .st_full(st_full),
    .wr0_en(wr0_en), .wr0_addr(wr0_addr), .wr0_bank_end(wr0_bank_end),
    .wr0_bgn_ben(wr0_bgn_ben), .wr0_end_ben(wr0_end_ben), .wr0_data(wr0_data),
    .wr1_en(wr1_en), .wr1_addr(wr1_addr), .wr1_bank_end(wr1_bank_end),
    .wr1_bgn_ben(wr1_bgn_ben), .wr1_end_ben(wr1_end_ben), .wr1_data(wr1_data)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // compare one write port with the oldest waiting store
  task automatic check_write(
    input  int                    port,
    input  logic [`ST_ADDR_W-1:0] addr,
    input  logic [`BANK_W-1:0]    bank_end,
    input  logic [`BEN_W-1:0]     bben,
    input  logic [`BEN_W-1:0]     eben,
    input  logic [`LANE_W-1:0]    data,
    output logic [`BANK_W-1:0]    bgn,
    output logic [`BANK_W-1:0]    bend
  );
    st_entry_t          e;
    int unsigned        acc_cyc;
    logic [`BEN_W-1:0]  x_bben;
    logic [`BEN_W-1:0]  x_eben;
    logic [`LANE_W-1:0] x_lane;

    if (exp_q.size() == 0) begin
      $display("write on port %0d at %0t with no store waiting", port, $time);
      error_count++;
      bgn  = addr[`BANK_W+1:2];
      bend = bank_end;
    end else begin
      e       = exp_q.pop_front();
      acc_cyc = acc_cyc_q.pop_front();
      decode_store(e, bgn, bend, x_bben, x_eben, x_lane);
      writes_checked++;
      // earliest write is two cycles after the accept
      if (sample_cyc < acc_cyc + 2) begin
        $display("error at %0t: port %0d wrote a store accepted %0d cycles before",
                 $time, port, sample_cyc - acc_cyc);
        error_count++;
      end
      if (addr !== e.addr) begin
        $display("error at %0t: port %0d addr %h, expected %h", $time, port, addr, e.addr);
        error_count++;
      end
      if (bank_end !== bend) begin
        $display("error at %0t: port %0d bank_end %0d, expected %0d",
                 $time, port, bank_end, bend);
        error_count++;
      end
      if (bben !== x_bben || eben !== x_eben) begin
        $display("error at %0t: port %0d ben %b/%b, expected %b/%b",
                 $time, port, bben, eben, x_bben, x_eben);
        error_count++;
      end
      if (data !== x_lane) begin
        $display("error at %0t: port %0d data %h, expected %h", $time, port, data, x_lane);
        error_count++;
      end
      if (x_eben != 4'd0) begin
        cross_seen++;
        if (bgn == 5'd31) begin
          wrap_seen++;
        end
      end
    end
  endtask

  task automatic drive_random();
    if (hold_left > 0) begin
      cache_hold = 1'b1;
      hold_left--;
    end else begin
      cache_hold = 1'b0;
      if (($urandom % 100) < 4) begin
        hold_left = 1 + $urandom % 48;
      end
    end
    st_in_valid = !st_full && (($urandom % 100) < 70);
    st_in_addr  = `ST_ADDR_W'($urandom);
    st_in_size  = st_size_t'(2'($urandom % 3));
    st_in_data  = $urandom;
  endtask

  // sample at the falling edge, where everything is settled
  always @(negedge clk) begin
    logic [`BANK_W-1:0] b0, e0, b1, e1;
    st_entry_t          ent;

    if (!reset) begin
      if (wr1_en && !wr0_en) begin
        $display("port 1 wrote without port 0 at %0t", $time);
        error_count++;
      end
      if ((wr0_en || wr1_en) && hold_d2) begin
        $display("write at %0t although cache_hold was high two cycles before", $time);
        error_count++;
      end
      if (wr0_en) begin
        check_write(0, wr0_addr, wr0_bank_end, wr0_bgn_ben, wr0_end_ben, wr0_data, b0, e0);
      end
      if (wr1_en) begin
        check_write(1, wr1_addr, wr1_bank_end, wr1_bgn_ben, wr1_end_ben, wr1_data, b1, e1);
        if (wr0_en && (b1 == b0 || b1 == e0 || e1 == b0 || e1 == e0)) begin
          $display("ports 0 and 1 share a bank at %0t", $time);
          error_count++;
        end
      end
      // waiting stores now match the queue occupancy
      if (st_full !== (exp_q.size() == `STQ_DEPTH)) begin
        $display("error at %0t: st_full %b with %0d stores waiting",
                 $time, st_full, exp_q.size());
        error_count++;
      end
      if (st_full) begin
        full_seen = 1'b1;
      end
      if (st_in_valid && !st_full) begin
        ent.addr = st_in_addr;
        ent.size = st_in_size;
        ent.data = st_in_data;
        exp_q.push_back(ent);
        acc_cyc_q.push_back(sample_cyc);
        accepted_count++;
      end
      hold_d2 = hold_d1;
      hold_d1 = cache_hold;
      sample_cyc++;
    end
  end

  initial begin
    void'($urandom(SEED));
    reset       = 1'b1;
    st_in_valid = 1'b0;
    st_in_addr  = '0;
    st_in_size  = SIZE_1;
    st_in_data  = '0;
    cache_hold  = 1'b0;
    hold_left   = 0;
    drain_wait  = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
    for (cyc = 0; cyc < STIM_CYCLES; cyc++) begin
      @(posedge clk);
      #1 drive_random();
    end
    @(posedge clk);
    #1 st_in_valid = 1'b0;
    cache_hold = 1'b0;
    while (exp_q.size() != 0 && drain_wait < DRAIN_CYCLES) begin
      @(posedge clk);
      drain_wait++;
    end
    // nothing extra may follow the drain
    repeat (4) @(posedge clk);
    if (!full_seen) begin
      $display("st_full never rose during the cache holds");
      error_count++;
    end
    if (cross_seen == 0 || wrap_seen == 0) begin
      $display("no store crossed a bank or wrapped from bank 31 to bank 0");
      error_count++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d accepted stores were never written", exp_q.size());
      error_count++;
    end
    $display("summary: %0d accepted, %0d written, %0d crossing, %0d wrapping, %0d errors",
             accepted_count, writes_checked, cross_seen, wrap_seen, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+source
+incdir+bench
source/store_pkg.sv
source/store_queue_count.sv
source/store_entry_buffer.sv
source/store_bank_decode.sv
source/store_drain_fsm.sv
source/store_write_path.sv
bench/store_tb.sv

/* Makefile */
VERILATOR  = verilator
VFLAGS     = --timing --assert -j 0
TOP        = store_tb
FILELIST   = compile.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "log check ok"; \
	else \
		echo "log check failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
